/* tcp_rx_pkg.sv */
`default_nettype none

package tcp_rx_pkg;

    // ========================================
    // Widths and counts
    // ========================================

    localparam int num_flows = 8;
    localparam int flowid_w = 3;
    localparam int rx_payload_ptr_w = 12;          // Buffer offset, pointers add a wrap bit
    localparam int xy_w = 4;
    localparam int fbits_w = 4;
    localparam int noc_data_w = 128;
    localparam int msg_len_w = 8;

    localparam logic [fbits_w-1:0] tcp_rx_app_ptr_if_fbits = 4'h2;   // Our own source endpoint

    // Head and commit pointers, offset plus wrap bit
    typedef logic [rx_payload_ptr_w:0] rx_ptr_t;

    // ========================================
    // Opcodes and states
    // ========================================

    typedef enum logic [7:0] {
        tcp_rx_msg_req  = 8'd0,
        tcp_rx_msg_resp = 8'd1,
        tcp_tx_msg_req  = 8'd2
    } msg_type_e;

    typedef enum logic {
        st_idle,
        st_send                                     // Flit valid, waiting for the network
    } ctrl_state_e;

    // ========================================
    // Flit and request layouts
    // ========================================

    typedef struct packed {
        logic [xy_w-1:0]      dst_x_coord;
        logic [xy_w-1:0]      dst_y_coord;
        logic [fbits_w-1:0]   dst_fbits;
        logic [msg_len_w-1:0] msg_len;          // Flits after the header
        msg_type_e            msg_type;
        logic [xy_w-1:0]      src_x_coord;
        logic [xy_w-1:0]      src_y_coord;
        logic [fbits_w-1:0]   src_fbits;
    } noc_hdr_core_t;

    typedef struct packed {
        logic [flowid_w-1:0]         flowid;
        rx_ptr_t                     head_ptr;
        logic [rx_payload_ptr_w-1:0] length;
    } rx_ptr_inner_t;

    localparam int flit_pad_w = noc_data_w - $bits(noc_hdr_core_t) - $bits(rx_ptr_inner_t);

    typedef struct packed {
        noc_hdr_core_t         core;
        rx_ptr_inner_t         inner;
        logic [flit_pad_w-1:0] padding;
    } tcp_noc_hdr_flit_t;

    typedef struct packed {
        logic [xy_w-1:0]    x;
        logic [xy_w-1:0]    y;
        logic [fbits_w-1:0] fbits;
    } noc_dst_t;

    typedef struct packed {
        logic [flowid_w-1:0]         flowid;
        rx_ptr_t                     head_ptr;
        logic [rx_payload_ptr_w-1:0] len;
        noc_dst_t                    dst;
    } notify_req_t;

endpackage

`default_nettype wire

/* rx_ptr_table.sv */
`default_nettype none

module rx_ptr_table (
    input  wire                                 clk,
    input  wire                                 rst,

    // ========================================
    // Update strobes
    // ========================================
    input  wire                                 commit_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     commit_flowid,
    input  wire  tcp_rx_pkg::rx_ptr_t           commit_ptr,

    input  wire                                 consume_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     consume_flowid,
    input  wire  tcp_rx_pkg::rx_ptr_t           consume_ptr,

    input  wire                                 reg_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     reg_flowid,
    input  wire  tcp_rx_pkg::noc_dst_t          reg_dst,

    input  wire                                 clear_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     clear_flowid,

    // ========================================
    // Per-flow state
    // ========================================
    output logic [tcp_rx_pkg::num_flows-1:0]    pending,
    output tcp_rx_pkg::rx_ptr_t  [tcp_rx_pkg::num_flows-1:0] commit_ptrs,
    output tcp_rx_pkg::rx_ptr_t  [tcp_rx_pkg::num_flows-1:0] head_ptrs,
    output tcp_rx_pkg::noc_dst_t [tcp_rx_pkg::num_flows-1:0] dsts
);

    logic [tcp_rx_pkg::num_flows-1:0] pending_next;

    // A commit in the same cycle as a clear must survive, so the set goes last
    always_comb begin
        pending_next = pending;
        if (clear_val) begin
            pending_next[clear_flowid] = 1'b0;
        end
        if (commit_val) begin
            pending_next[commit_flowid] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end
        else begin
            pending <= pending_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_ptrs <= '0;
        end
        else if (commit_val) begin
            commit_ptrs[commit_flowid] <= commit_ptr;   // Receive engine has written up to here
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptrs <= '0;
        end
        else if (consume_val) begin
            head_ptrs[consume_flowid] <= consume_ptr;   // Application has read up to here
        end
    end

    // Endpoint registrations are plain storage
    always_ff @(posedge clk) begin
        if (reg_val) begin
            dsts[reg_flowid] <= reg_dst;
        end
    end

endmodule

`default_nettype wire

/* rx_flow_poller.sv */
`default_nettype none

module rx_flow_poller (
    input  wire                                 clk,
    input  wire                                 rst,

    input  wire  [tcp_rx_pkg::num_flows-1:0]    pending,
    input  wire  tcp_rx_pkg::rx_ptr_t  [tcp_rx_pkg::num_flows-1:0] commit_ptrs,
    input  wire  tcp_rx_pkg::rx_ptr_t  [tcp_rx_pkg::num_flows-1:0] head_ptrs,
    input  wire  tcp_rx_pkg::noc_dst_t [tcp_rx_pkg::num_flows-1:0] dsts,

    input  wire                                 req_take,
    output logic                                req_val,
    output tcp_rx_pkg::notify_req_t             req,

    output logic                                clear_val,
    output logic [tcp_rx_pkg::flowid_w-1:0]     clear_flowid
);

    logic [tcp_rx_pkg::flowid_w-1:0] last_grant;
    logic [tcp_rx_pkg::flowid_w-1:0] grant_id;
    logic                            found;
    tcp_rx_pkg::rx_ptr_t             commit_sel;
    tcp_rx_pkg::rx_ptr_t             head_sel;

    // ========================================
    // Round-robin search
    // ========================================

    // First pending flow after the last grant, wrapping back to it last
    always_comb begin
        int cand;
        found = 1'b0;
        grant_id = '0;
        for (int i = 1; i <= tcp_rx_pkg::num_flows; i++) begin
            cand = (int'(last_grant) + i) % tcp_rx_pkg::num_flows;
            if (!found && pending[cand]) begin
                found = 1'b1;
                grant_id = cand[tcp_rx_pkg::flowid_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= tcp_rx_pkg::flowid_w'(tcp_rx_pkg::num_flows - 1);  // Flow 0 goes first
        end
        else if (req_take) begin
            last_grant <= grant_id;
        end
    end

    // ========================================
    // Request build
    // ========================================

    assign commit_sel = commit_ptrs[grant_id];
    assign head_sel = head_ptrs[grant_id];

    always_comb begin
        req_val = found;
        req.flowid = grant_id;
        req.head_ptr = head_sel;
        req.len = commit_sel[tcp_rx_pkg::rx_payload_ptr_w-1:0]
                - head_sel[tcp_rx_pkg::rx_payload_ptr_w-1:0];   // Wrap bit drops out
        req.dst = dsts[grant_id];
    end

    assign clear_val = req_take;                // Table keeps the bit if a commit collides
    assign clear_flowid = grant_id;

endmodule

`default_nettype wire

/* rx_msg_noc_if_ctrl.sv */
`default_nettype none

module rx_msg_noc_if_ctrl (
    input  wire   clk,
    input  wire   rst,

    input  wire   req_val,
    output logic  req_take,

    output logic  noc_val,
    input  wire   noc_rdy
);

    tcp_rx_pkg::ctrl_state_e state;
    tcp_rx_pkg::ctrl_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tcp_rx_pkg::st_idle;
        end
        else begin
            state <= state_next;
        end
    end

    // ========================================
    // One take per accepted flit
    // ========================================

    always_comb begin
        state_next = state;
        req_take = 1'b0;
        noc_val = 1'b0;
        case (state)
            tcp_rx_pkg::st_idle: begin
                if (req_val) begin
                    req_take = 1'b1;
                    state_next = tcp_rx_pkg::st_send;
                end
            end
            tcp_rx_pkg::st_send: begin
                noc_val = 1'b1;
                if (noc_rdy) begin
                    // The datapath register frees up at this edge, so refill it now
                    if (req_val) begin
                        req_take = 1'b1;
                    end
                    else begin
                        state_next = tcp_rx_pkg::st_idle;
                    end
                end
            end
            default: begin
                state_next = tcp_rx_pkg::st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rx_msg_noc_if_datap.sv */
`default_nettype none

module rx_msg_noc_if_datap #(
    parameter int src_x = 0,
    parameter int src_y = 0
) (
    input  wire                                 clk,
    input  wire                                 rst,

    input  wire  tcp_rx_pkg::notify_req_t       req,
    input  wire                                 ctrl_datap_store_inputs,

    output logic [tcp_rx_pkg::noc_data_w-1:0]   noc_data
);

    localparam logic [tcp_rx_pkg::xy_w-1:0] src_x_coord = src_x[tcp_rx_pkg::xy_w-1:0];
    localparam logic [tcp_rx_pkg::xy_w-1:0] src_y_coord = src_y[tcp_rx_pkg::xy_w-1:0];

    tcp_rx_pkg::notify_req_t       req_reg;
    tcp_rx_pkg::notify_req_t       req_next;
    tcp_rx_pkg::tcp_noc_hdr_flit_t hdr_flit;

    // ========================================
    // Request latch
    // ========================================

    always_comb begin
        if (ctrl_datap_store_inputs) begin
            req_next = req;
        end
        else begin
            req_next = req_reg;                 // Hold while the flit waits on the network
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_reg <= '0;
        end
        else begin
            req_reg <= req_next;
        end
    end

    // ========================================
    // Header flit
    // ========================================

    always_comb begin
        hdr_flit = '0;

        hdr_flit.core.dst_x_coord = req_reg.dst.x;
        hdr_flit.core.dst_y_coord = req_reg.dst.y;
        hdr_flit.core.dst_fbits = req_reg.dst.fbits;
        hdr_flit.core.msg_len = '0;             // Header only
        hdr_flit.core.msg_type = tcp_rx_pkg::tcp_rx_msg_resp;
        hdr_flit.core.src_x_coord = src_x_coord;
        hdr_flit.core.src_y_coord = src_y_coord;
        hdr_flit.core.src_fbits = tcp_rx_pkg::tcp_rx_app_ptr_if_fbits;

        hdr_flit.inner.flowid = req_reg.flowid;
        hdr_flit.inner.head_ptr = req_reg.head_ptr;
        hdr_flit.inner.length = req_reg.len;
    end

    assign noc_data = hdr_flit;

endmodule

`default_nettype wire

/* rx_notify_top.sv */
`default_nettype none

module rx_notify_top #(
    parameter int src_x = 0,
    parameter int src_y = 0
) (
    input  wire                                 clk,
    input  wire                                 rst,

    input  wire                                 commit_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     commit_flowid,
    input  wire  tcp_rx_pkg::rx_ptr_t           commit_ptr,

    input  wire                                 consume_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     consume_flowid,
    input  wire  tcp_rx_pkg::rx_ptr_t           consume_ptr,

    input  wire                                 reg_val,
    input  wire  [tcp_rx_pkg::flowid_w-1:0]     reg_flowid,
    input  wire  tcp_rx_pkg::noc_dst_t          reg_dst,

    output logic [tcp_rx_pkg::noc_data_w-1:0]   noc_data,
    output logic                                noc_val,
    input  wire                                 noc_rdy
);

    logic [tcp_rx_pkg::num_flows-1:0]               pending;
    tcp_rx_pkg::rx_ptr_t  [tcp_rx_pkg::num_flows-1:0] commit_ptrs;
    tcp_rx_pkg::rx_ptr_t  [tcp_rx_pkg::num_flows-1:0] head_ptrs;
    tcp_rx_pkg::noc_dst_t [tcp_rx_pkg::num_flows-1:0] dsts;
    logic                                           clear_val;
    logic [tcp_rx_pkg::flowid_w-1:0]                clear_flowid;
    logic                                           req_val;
    logic                                           req_take;
    tcp_rx_pkg::notify_req_t                        req;

    rx_ptr_table u_table (
        .clk            (clk),
        .rst            (rst),
        .commit_val     (commit_val),
        .commit_flowid  (commit_flowid),
        .commit_ptr     (commit_ptr),
        .consume_val    (consume_val),
        .consume_flowid (consume_flowid),
        .consume_ptr    (consume_ptr),
        .reg_val        (reg_val),
        .reg_flowid     (reg_flowid),
        .reg_dst        (reg_dst),
        .clear_val      (clear_val),
        .clear_flowid   (clear_flowid),
        .pending        (pending),
        .commit_ptrs    (commit_ptrs),
        .head_ptrs      (head_ptrs),
        .dsts           (dsts)
    );

    rx_flow_poller u_poller (
        .clk            (clk),
        .rst            (rst),
        .pending        (pending),
        .commit_ptrs    (commit_ptrs),
        .head_ptrs      (head_ptrs),
        .dsts           (dsts),
        .req_take       (req_take),
        .req_val        (req_val),
        .req            (req),
        .clear_val      (clear_val),
        .clear_flowid   (clear_flowid)
    );

    rx_msg_noc_if_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_val        (req_val),
        .req_take       (req_take),
        .noc_val        (noc_val),
        .noc_rdy        (noc_rdy)
    );

    // The take pulse doubles as the datapath store strobe
    rx_msg_noc_if_datap #(
        .src_x          (src_x),
        .src_y          (src_y)
    ) u_datap (
        .clk                     (clk),
        .rst                     (rst),
        .req                     (req),
        .ctrl_datap_store_inputs (req_take),
        .noc_data                (noc_data)
    );

endmodule

`default_nettype wire

/* tb_rx_notify.sv */
`default_nettype none

module tb_rx_notify;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 100;
    localparam int test_steps = 7;
    localparam int watchdog_cycles = test_steps * 200 + 300;

    logic                                   clk = 1'b0;
    logic                                   rst;
    logic                                   commit_val;
    logic [2:0]                             commit_flowid;
    logic [12:0]                            commit_ptr;
    logic                                   consume_val;
    logic [2:0]                             consume_flowid;
    logic [12:0]                            consume_ptr;
    logic                                   reg_val;
    logic [2:0]                             reg_flowid;
    tcp_rx_pkg::noc_dst_t                   reg_dst;
    logic [127:0]                           noc_data;
    logic                                   noc_val;
    logic                                   noc_rdy;

    // Reference model of the per-flow table and the flit in flight
    logic [12:0]                            model_commit [8];
    logic [12:0]                            model_head [8];
    tcp_rx_pkg::noc_dst_t                   model_dst [8];
    logic [7:0]                             model_pending;
    logic [2:0]                             model_last;
    logic                                   flit_busy;
    tcp_rx_pkg::tcp_noc_hdr_flit_t          exp_flit;
    logic                                   stall_prev;
    logic [127:0]                           stall_data;
    int                                     accepted_ids [$];
    integer                                 seed = 32'h2486_876c;

    rx_notify_top #(.src_x(3), .src_y(5)) uut (
        .clk            (clk),
        .rst            (rst),
        .commit_val     (commit_val),
        .commit_flowid  (commit_flowid),
        .commit_ptr     (commit_ptr),
        .consume_val    (consume_val),
        .consume_flowid (consume_flowid),
        .consume_ptr    (consume_ptr),
        .reg_val        (reg_val),
        .reg_flowid     (reg_flowid),
        .reg_dst        (reg_dst),
        .noc_data       (noc_data),
        .noc_val        (noc_val),
        .noc_rdy        (noc_rdy)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("Error at %0d ns: %s", $time, msg));
    endtask

    function automatic tcp_rx_pkg::tcp_noc_hdr_flit_t expected_flit(input int f);
        tcp_rx_pkg::tcp_noc_hdr_flit_t e;
        e = '0;                                     // Leaves msg_len and padding at zero
        e.core.dst_x_coord = model_dst[f].x;
        e.core.dst_y_coord = model_dst[f].y;
        e.core.dst_fbits = model_dst[f].fbits;
        e.core.msg_type = tcp_rx_pkg::tcp_rx_msg_resp;
        e.core.src_x_coord = 4'd3;
        e.core.src_y_coord = 4'd5;
        e.core.src_fbits = 4'h2;
        e.inner.flowid = 3'(f);
        e.inner.head_ptr = model_head[f];
        e.inner.length = model_commit[f][11:0] - model_head[f][11:0];
        return e;
    endfunction

    // ========================================
    // Model update and flit checks
    // ========================================

    always @(posedge clk) begin
        tcp_rx_pkg::tcp_noc_hdr_flit_t got;
        int cand;
        int grant;
        got = noc_data;
        grant = 0;
        if (rst) begin
            model_pending = '0;
            model_last = 3'd7;
            flit_busy = 1'b0;
            stall_prev = 1'b0;
            for (int f = 0; f < 8; f++) begin
                model_commit[f] = '0;
                model_head[f] = '0;
            end
        end
        else begin
            assert (noc_val == flit_busy)
                else report_mismatch($sformatf("noc_val is %0b, expected %0b", noc_val, flit_busy));
            if (stall_prev) begin
                assert (noc_data == stall_data)
                    else report_mismatch("noc_data changed while noc_rdy was low");
            end
            stall_prev = noc_val && !noc_rdy;
            stall_data = noc_data;
            if (noc_val && noc_rdy) begin
                assert (got.core == exp_flit.core)
                    else report_mismatch($sformatf("header core %h, expected %h",
                                                   got.core, exp_flit.core));
                assert (got.inner == exp_flit.inner)
                    else report_mismatch($sformatf("flow fields %h, expected %h",
                                                   got.inner, exp_flit.inner));
                assert (got.padding == '0)
                    else report_mismatch("flit padding is not zero");
                accepted_ids.push_back(int'(got.inner.flowid));
                flit_busy = 1'b0;
            end
            // A free datapath register takes the next flow in round-robin order
            if (!flit_busy && model_pending != '0) begin
                for (int i = 8; i >= 1; i--) begin
                    cand = (int'(model_last) + i) % 8;
                    if (model_pending[cand]) begin
                        grant = cand;
                    end
                end
                exp_flit = expected_flit(grant);
                model_pending[grant] = 1'b0;
                model_last = 3'(grant);
                flit_busy = 1'b1;
            end
            if (commit_val) begin
                model_commit[commit_flowid] = commit_ptr;
                model_pending[commit_flowid] = 1'b1;  // Wins over a clear in the same cycle
            end
            if (consume_val) begin
                model_head[consume_flowid] = consume_ptr;
            end
            if (reg_val) begin
                model_dst[reg_flowid] = reg_dst;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic pulse_commit(input int f, input logic [12:0] ptr);
        commit_val = 1'b1;
        commit_flowid = 3'(f);
        commit_ptr = ptr;
        @(negedge clk);
        commit_val = 1'b0;
    endtask

    task automatic pulse_consume(input int f, input logic [12:0] ptr);
        consume_val = 1'b1;
        consume_flowid = 3'(f);
        consume_ptr = ptr;
        @(negedge clk);
        consume_val = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        noc_rdy = 1'b1;
        while ((model_pending != '0 || flit_busy) && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (n >= 200) begin
            abort_run("Flows still pending 200 cycles after the last update");
        end
        @(negedge clk);
    endtask

    task automatic check_flit_order(input int count, input int first, input int stride);
        assert (accepted_ids.size() == count)
            else report_mismatch($sformatf("%0d flits accepted, expected %0d",
                                           accepted_ids.size(), count));
        foreach (accepted_ids[i]) begin
            assert (accepted_ids[i] == (first + i * stride) % 8)
                else report_mismatch($sformatf("flit %0d is for flow %0d, expected %0d",
                                               i, accepted_ids[i], (first + i * stride) % 8));
        end
        accepted_ids.delete();
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run("Watchdog timeout, the test sequence did not finish in time");
    end

    initial begin
        int f;
        int start;
        logic [12:0] gap;
        rst = 1'b1;
        commit_val = 1'b0;
        commit_flowid = '0;
        commit_ptr = '0;
        consume_val = 1'b0;
        consume_flowid = '0;
        consume_ptr = '0;
        reg_val = 1'b0;
        reg_flowid = '0;
        reg_dst = '0;
        noc_rdy = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin       // Endpoints only so nothing becomes pending
            reg_val = 1'b1;
            reg_flowid = 3'(i);
            reg_dst = 12'($random(seed));
            @(negedge clk);
        end
        reg_val = 1'b0;
        repeat (10) begin
            @(negedge clk);
            assert (!noc_val) else report_mismatch("noc_val high with no commit");
        end

        pulse_commit(2, 13'd100);
        wait_drain();
        check_flit_order(1, 2, 0);

        pulse_commit(5, 13'h0ff8);              // Consume and commit across the wrap bit
        wait_drain();
        accepted_ids.delete();
        pulse_consume(5, 13'h0ff0);
        pulse_commit(5, 13'h1010);
        wait_drain();
        check_flit_order(1, 5, 0);

        pulse_commit(1, model_commit[1] + 13'd5);
        pulse_commit(1, model_commit[1] + 13'd9);   // Lands in the take cycle
        wait_drain();
        check_flit_order(2, 1, 0);
        noc_rdy = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            pulse_commit(3, model_commit[3] + 13'(k * 10));
        end
        wait_drain();
        check_flit_order(2, 3, 0);

        noc_rdy = 1'b0;
        pulse_commit(4, model_commit[4] + 13'd64);
        repeat (20) @(negedge clk);
        assert (noc_val) else report_mismatch("noc_val dropped while stalled");
        wait_drain();
        check_flit_order(1, 4, 0);

        noc_rdy = 1'b0;
        start = (int'(model_last) + 1) % 8;
        for (int k = 0; k < 8; k++) begin
            pulse_commit((start + k) % 8, model_commit[(start + k) % 8] + 13'd16);
        end
        wait_drain();
        check_flit_order(8, start, 1);

        // Mixed traffic with random back-pressure
        repeat (150) begin
            noc_rdy = (($random(seed) & 3) != 0);
            f = int'($unsigned($random(seed)) % 8);
            gap = model_commit[f] - model_head[f];
            if ((($random(seed) & 1) != 0) && gap < 13'd3000) begin
                commit_val = 1'b1;
                commit_flowid = 3'(f);
                commit_ptr = model_commit[f] + 13'(1 + $unsigned($random(seed)) % 255);
            end
            f = int'($unsigned($random(seed)) % 8);
            gap = model_commit[f] - model_head[f];
            if (($random(seed) & 3) == 0) begin
                consume_val = 1'b1;
                consume_flowid = 3'(f);
                consume_ptr = model_head[f] + (gap >> 1);
            end
            @(negedge clk);
            commit_val = 1'b0;
            consume_val = 1'b0;
        end
        wait_drain();

        repeat (3) @(negedge clk);
        if (uut.pending != '0 || noc_val) begin
            $display("Flows still pending at the end of the test");
            $display("Simulation failed");
            $fatal(1, "run stopped");
        end
        else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
tcp_rx_pkg.sv
rx_ptr_table.sv
rx_flow_poller.sv
rx_msg_noc_if_ctrl.sv
rx_msg_noc_if_datap.sv
rx_notify_top.sv
tb_rx_notify.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the receive notification testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_rx_notify --Mdir obj_dir -o tb_rx_notify
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_rx_notify
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
